// File: link_pkg.sv
// shared word, state and status types plus link constants, imported by every link test module
package link_pkg;

    // one data word on the link
    typedef logic [31:0] word_t;

    // prbs31 shift register
    typedef logic [30:0] prbs_state_t;

    // crc32 register
    typedef logic [31:0] crc_state_t;

    // saturating error bit count
    typedef logic [15:0] err_count_t;

    // transmit or receive word with its valid level
    typedef struct packed {
        logic  valid;
        word_t data;
    } link_word_t;

    // checker output, one flag per received bit
    typedef struct packed {
        logic  valid;
        word_t err;
    } chk_result_t;

    // lock state and running error total
    typedef struct packed {
        logic       locked;
        err_count_t err_count;
    } link_status_t;

    // x^31 + x^28 + 1, top term implied
    localparam prbs_state_t prbs_poly = 31'h10000001;
    localparam prbs_state_t prbs_seed = '1;

    // ethernet crc32, top term implied
    localparam crc_state_t crc_poly = 32'h04c11db7;
    localparam crc_state_t crc_init = '1;

    // clean checked words needed before lock is declared
    localparam int lock_words = 4;

endpackage

// File: lfsr_step.sv
// combinational parallel lfsr step, instantiated by the prbs generator, prbs checker and crc engine
module lfsr_step #(
    parameter type state_t = logic [31:0],
    parameter type data_t = logic [31:0],
    // polynomial without the top term
    parameter state_t poly = '0,
    // galois when set, fibonacci otherwise
    parameter bit galois = 1'b0,
    // shift in data only, used for self-synchronising checkers
    parameter bit feed_forward = 1'b0,
    // lsb first shifting with reflected state
    parameter bit reverse = 1'b0
) (
    input  data_t  data_in,
    input  state_t state_in,
    output data_t  data_out,
    output state_t state_out
);

    localparam int sw = $bits(state_t);
    localparam int dw = $bits(data_t);
    // combined input vector is {state, data}
    localparam int cw = sw + dw;
    // sw next state rows, then dw output rows
    localparam int rows = sw + dw;
    localparam logic [sw-1:0] poly_bits = poly;

    typedef logic [rows-1:0][cw-1:0] mask_set_t;

    // reverse the state part and the data part of one mask row separately
    function automatic logic [cw-1:0] flip_row(input logic [cw-1:0] m);
        logic [cw-1:0] r;
        r = '0;
        for (int k = 0; k < dw; k++) begin
            r[k] = m[dw-1-k];
        end
        for (int k = 0; k < sw; k++) begin
            r[dw+k] = m[cw-1-k];
        end
        return r;
    endfunction

    // decode: run the register symbolically, one shift per data bit
    function automatic mask_set_t calc_masks();
        logic [sw-1:0][cw-1:0] sm;
        logic [dw-1:0][cw-1:0] om;
        logic [cw-1:0] fb;
        mask_set_t res;
        sm = '0;
        om = '0;
        res = '0;
        // each flop starts as its own state input
        for (int i = 0; i < sw; i++) begin
            sm[i][dw+i] = 1'b1;
        end
        // data bits enter msb first
        for (int i = dw - 1; i >= 0; i--) begin
            fb = sm[sw-1];
            fb[i] = fb[i] ^ 1'b1;
            // fibonacci folds the taps into the feedback
            if (!galois) begin
                for (int j = 1; j < sw; j++) begin
                    if (poly_bits[j]) begin
                        fb = fb ^ sm[j-1];
                    end
                end
            end
            om = {om[dw-2:0], fb};
            if (feed_forward) begin
                fb = '0;
                fb[i] = 1'b1;
            end
            sm = {sm[sw-2:0], fb};
            // galois injects the feedback at each tap
            if (galois) begin
                for (int j = 1; j < sw; j++) begin
                    if (poly_bits[j]) begin
                        sm[j] = sm[j] ^ fb;
                    end
                end
            end
        end
        // row order flips too when reversed
        for (int r = 0; r < sw; r++) begin
            res[r] = reverse ? flip_row(sm[sw-1-r]) : sm[r];
        end
        for (int r = 0; r < dw; r++) begin
            res[sw+r] = reverse ? flip_row(om[dw-1-r]) : om[r];
        end
        return res;
    endfunction

    localparam mask_set_t masks = calc_masks();

    logic [cw-1:0] in_vec;
    logic [sw-1:0] next_state;
    logic [dw-1:0] next_data;

    assign in_vec = {state_in, data_in};

    // execute: each output bit is the parity of its masked inputs
    for (genvar n = 0; n < sw; n++) begin : g_state
        assign next_state[n] = ^(in_vec & masks[n]);
    end

    for (genvar n = 0; n < dw; n++) begin : g_data
        assign next_data[n] = ^(in_vec & masks[sw+n]);
    end

    assign state_out = state_t'(next_state);
    assign data_out = data_t'(next_data);

endmodule

// File: prbs_gen.sv
// prbs31 transmit word generator, 32 serial bits per enabled cycle, msb first on tx.data
module prbs_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                gen_enable,
    output link_pkg::link_word_t tx
);

    import link_pkg::*;

    prbs_state_t state;
    prbs_state_t state_next;
    word_t       word_next;
    logic        tx_valid;
    word_t       tx_data;

    // fibonacci, no input data
    lfsr_step #(
        .state_t      (prbs_state_t),
        .data_t       (word_t),
        .poly         (prbs_poly),
        .galois       (1'b0),
        .feed_forward (1'b0),
        .reverse      (1'b0)
    ) u_step (
        .data_in   ('0),
        .state_in  (state),
        .data_out  (word_next),
        .state_out (state_next)
    );

    // state holds while paused
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= prbs_seed;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= gen_enable;
            if (gen_enable) begin
                state <= state_next;
            end
        end
    end

    // word register
    always_ff @(posedge clk) begin
        if (gen_enable) begin
            tx_data <= word_next;
        end
    end

    assign tx = '{valid: tx_valid, data: tx_data};

    // the all zero state would lock the sequence up for good
    assert property (@(posedge clk) disable iff (reset) state != '0)
        else $error("prbs_gen: state reached all zero");

endmodule

// File: prbs_check.sv
// self-synchronising prbs31 checker, flags every receive bit that breaks the recurrence
module prbs_check (
    input  logic                  clk,
    input  logic                  reset,
    input  link_pkg::link_word_t  rx,
    output link_pkg::chk_result_t result
);

    import link_pkg::*;

    prbs_state_t state;
    prbs_state_t state_next;
    word_t       err_next;
    logic        primed;
    logic        res_valid;
    word_t       res_err;

    // feed-forward, state is just the last 31 received bits
    lfsr_step #(
        .state_t      (prbs_state_t),
        .data_t       (word_t),
        .poly         (prbs_poly),
        .galois       (1'b0),
        .feed_forward (1'b1),
        .reverse      (1'b0)
    ) u_step (
        .data_in   (rx.data),
        .state_in  (state),
        .data_out  (err_next),
        .state_out (state_next)
    );

    // history refill on every valid word
    always_ff @(posedge clk) begin
        if (rx.valid) begin
            state   <= state_next;
            res_err <= err_next;
        end
    end

    // first word after reset only fills the history
    always_ff @(posedge clk) begin
        if (reset) begin
            primed    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= rx.valid && primed;
            if (rx.valid) begin
                primed <= 1'b1;
            end
        end
    end

    assign result = '{valid: res_valid, err: res_err};

    // one cycle latency from a valid receive word
    assert property (@(posedge clk) disable iff (reset) result.valid |-> $past(rx.valid))
        else $error("prbs_check: result without a receive word");

endmodule

// File: prbs_lock_monitor.sv
// counts checker error bits with saturation and tracks lock over runs of clean words
module prbs_lock_monitor (
    input  logic                   clk,
    input  logic                   reset,
    input  link_pkg::chk_result_t  result,
    output link_pkg::link_status_t status
);

    import link_pkg::*;

    localparam int run_w = $clog2(lock_words + 1);

    logic [5:0]       err_bits;
    logic [16:0]      err_sum;
    err_count_t       err_count;
    logic [run_w-1:0] clean_run;
    logic             locked;

    // popcount of the error word
    always_comb begin
        err_bits = '0;
        for (int k = 0; k < $bits(word_t); k++) begin
            err_bits = err_bits + 6'(result.err[k]);
        end
    end

    // one spare bit catches the overflow
    assign err_sum = {1'b0, err_count} + 17'(err_bits);

    always_ff @(posedge clk) begin
        if (reset) begin
            err_count <= '0;
            clean_run <= '0;
            locked    <= 1'b0;
        end else if (result.valid) begin
            // saturate at all ones
            err_count <= err_sum[16] ? '1 : err_sum[15:0];
            if (|result.err) begin
                // any bad bit drops lock and restarts the run
                clean_run <= '0;
                locked    <= 1'b0;
            end else if (clean_run == run_w'(lock_words - 1)) begin
                locked <= 1'b1;
            end else begin
                clean_run <= clean_run + 1'b1;
            end
        end
    end

    assign status = '{locked: locked, err_count: err_count};

    // count only ever grows between resets
    assert property (@(posedge clk) disable iff (reset)
        status.err_count >= $past(status.err_count))
        else $error("prbs_lock_monitor: err_count decreased");

endmodule

// File: crc32_engine.sv
// ethernet crc32 accumulator over receive words, restarted per frame by crc_clear
module crc32_engine (
    input  logic                 clk,
    input  logic                 reset,
    input  link_pkg::link_word_t rx,
    input  logic                 crc_clear,
    output link_pkg::crc_state_t fcs
);

    import link_pkg::*;

    crc_state_t crc;
    crc_state_t crc_base;
    crc_state_t crc_next;

    // clear wins, word on the clear cycle opens the new frame
    assign crc_base = crc_clear ? crc_init : crc;

    // galois, reflected so data goes in lsb first
    lfsr_step #(
        .state_t      (crc_state_t),
        .data_t       (word_t),
        .poly         (crc_poly),
        .galois       (1'b1),
        .feed_forward (1'b0),
        .reverse      (1'b1)
    ) u_step (
        .data_in   (rx.data),
        .state_in  (crc_base),
        .data_out  (),
        .state_out (crc_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            crc <= crc_init;
        end else if (rx.valid) begin
            crc <= crc_next;
        end else if (crc_clear) begin
            crc <= crc_init;
        end
    end

    // final inversion
    assign fcs = ~crc;

    // an unknown bit would poison the rest of the frame
    assert property (@(posedge clk) disable iff (reset) rx.valid |-> !$isunknown(rx.data))
        else $error("crc32_engine: unknown bits on rx.data");

endmodule

// File: link_test_top.sv
// link test top level with prbs31 generator, checker, lock monitor and crc32 engine
module link_test_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   gen_enable,
    input  link_pkg::link_word_t   rx,
    input  logic                   crc_clear,
    output link_pkg::link_word_t   tx,
    output link_pkg::link_status_t status,
    output link_pkg::crc_state_t   fcs
);

    import link_pkg::*;

    // checker to monitor
    chk_result_t check_result;

    // transmit side
    prbs_gen u_gen (
        .clk        (clk),
        .reset      (reset),
        .gen_enable (gen_enable),
        .tx         (tx)
    );

    // receive side checking
    prbs_check u_check (
        .clk    (clk),
        .reset  (reset),
        .rx     (rx),
        .result (check_result)
    );

    prbs_lock_monitor u_monitor (
        .clk    (clk),
        .reset  (reset),
        .result (check_result),
        .status (status)
    );

    // frame check sequence over the same receive words
    crc32_engine u_crc (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .crc_clear (crc_clear),
        .fcs       (fcs)
    );

endmodule

// File: tb_link_ref.svh
// reference models for the link testbench, included inside the testbench module body
`ifndef TB_LINK_REF_SVH
`define TB_LINK_REF_SVH

// prbs31 recurrence run over the received bits, hist[k] is the bit k+1 places back
function automatic word_t predict_prbs_word(input prbs_state_t hist, input word_t data);
    word_t       pred;
    prbs_state_t h;
    h = hist;
    // msb is the earliest serial bit
    for (int b = 31; b >= 0; b--) begin
        pred[b] = h[27] ^ h[30];
        h = {h[29:0], data[b]};
    end
    return pred;
endfunction

// reflected crc32, one bit at a time, lsb of each word first
function automatic crc_state_t crc32_bitwise(input word_t words[16], input int len);
    crc_state_t crc;
    logic       fb;
    crc = '1;
    for (int i = 0; i < len; i++) begin
        for (int b = 0; b < 32; b++) begin
            fb = crc[0] ^ words[i][b];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 32'hedb88320;
            end
        end
    end
    // final inversion
    return ~crc;
endfunction

// number of set bits in a word
function automatic int count_ones(input word_t v);
    int n;
    n = 0;
    for (int b = 0; b < 32; b++) begin
        n += int'(v[b]);
    end
    return n;
endfunction

`endif

// File: tb_link_test.sv
// testbench for the link test block, loops tx back into rx and checks prbs, lock, errors and crc
module tb_link_test;

    import link_pkg::*;

    `include "tb_link_ref.svh"

    localparam int reset_cycles = 16;
    localparam int prbs_words = 200;
    localparam int num_errors = 20;
    localparam int num_frames = 30;
    // worst case per phase, doubled for margin
    localparam int est_cycles = reset_cycles + prbs_words * 6
        + num_errors * (2 * lock_words + 10) + num_frames * 19 + 64;
    localparam int max_cycles = 2 * est_cycles;

    logic         clk;
    logic         reset;
    logic         gen_enable;
    logic         crc_clear;
    link_word_t   rx;
    link_word_t   tx;
    link_status_t status;
    crc_state_t   fcs;

    logic        loopback;
    logic        clean_phase;
    word_t       flip_mask;
    prbs_state_t prbs_hist;
    int          tx_words;
    int          exp_count;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles;
    word_t       frame_buf[16];

    link_test_top dut (
        .clk        (clk),
        .reset      (reset),
        .gen_enable (gen_enable),
        .rx         (rx),
        .crc_clear  (crc_clear),
        .tx         (tx),
        .status     (status),
        .fcs        (fcs)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // tx.valid follows gen_enable by one cycle
    assert property (@(posedge clk) disable iff (reset) !gen_enable |=> !tx.valid)
        else begin
            other_errors++;
            $display("tx.valid stayed high through a generator pause");
        end
    assert property (@(posedge clk) disable iff (reset) gen_enable |=> tx.valid)
        else begin
            other_errors++;
            $display("tx.valid stayed low while the generator was enabled");
        end
    // no error bit may be counted on a clean link
    assert property (@(posedge clk) disable iff (reset) clean_phase |-> status.err_count == '0)
        else begin
            other_errors++;
            $display("error bits counted during clean loopback");
        end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    // one cycle, outputs sampled at the falling edge, loopback driven right after
    task automatic tick();
        @(negedge clk);
        if (tx.valid) begin
            check_value("tx.data", tx.data, predict_prbs_word(prbs_hist, tx.data));
            // newest 31 serial bits, bit 0 the latest
            prbs_hist = tx.data[30:0];
            tx_words++;
        end
        if (loopback) begin
            rx.valid = tx.valid;
            rx.data = tx.data ^ flip_mask;
            if (tx.valid) begin
                flip_mask = '0;
            end
        end
    endtask

    task automatic wait_lock_state(input logic want, input int limit);
        int n;
        n = 0;
        while (status.locked !== want && n < limit) begin
            tick();
            n++;
        end
        check_value("status.locked", status.locked, want);
    endtask

    task automatic send_frame();
        int len;
        len = 1 + int'($urandom % 16);
        for (int i = 0; i < len; i++) begin
            frame_buf[i] = $urandom;
            rx.valid = 1'b1;
            rx.data = frame_buf[i];
            crc_clear = (i == 0);
            tick();
        end
        // fcs of the last word is visible now
        check_value("fcs", fcs, crc32_bitwise(frame_buf, len));
        rx.valid = 1'b0;
        crc_clear = 1'b0;
        repeat ($urandom % 3) tick();
    endtask

    initial begin
        void'($urandom(88));
        reset = 1'b1;
        // generator enabled through reset, which alone must keep it idle
        gen_enable = 1'b1;
        crc_clear = 1'b0;
        rx = '0;
        loopback = 1'b0;
        clean_phase = 1'b0;
        flip_mask = '0;
        // history starts as the all ones seed
        prbs_hist = '1;
        tx_words = 0;
        exp_count = 0;
        repeat (reset_cycles) @(negedge clk);
        // reset values, before any edge without reset
        check_value("tx.valid", tx.valid, 1'b0);
        check_value("status.locked", status.locked, 1'b0);
        check_value("status.err_count", status.err_count, 0);
        reset = 1'b0;

        // generator alone, random pauses, checker left idle
        while (tx_words < prbs_words) begin
            if ($urandom % 10 == 0) begin
                gen_enable = 1'b0;
                repeat (1 + $urandom % 5) tick();
            end
            gen_enable = 1'b1;
            tick();
        end

        // clean loopback
        clean_phase = 1'b1;
        loopback = 1'b1;
        wait_lock_state(1'b1, lock_words + 3);
        repeat (8) tick();
        check_value("status.err_count", status.err_count, 0);
        clean_phase = 1'b0;

        // single bit errors, each one seen at the bit and at both taps
        for (int e = 0; e < num_errors; e++) begin
            wait_lock_state(1'b1, lock_words + 3);
            flip_mask = 32'h1 << ($urandom % 32);
            exp_count += 3 * count_ones(flip_mask);
            tick();
            wait_lock_state(1'b0, 4);
            wait_lock_state(1'b1, lock_words + 3);
            check_value("status.err_count", status.err_count, exp_count);
        end

        // random frames for the crc
        loopback = 1'b0;
        gen_enable = 1'b0;
        rx = '0;
        repeat (num_frames) send_frame();

        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", max_cycles);
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
link_pkg.sv
lfsr_step.sv
prbs_gen.sv
prbs_check.sv
prbs_lock_monitor.sv
crc32_engine.sv
link_test_top.sv
tb_link_test.sv

// File: run.sh
#!/bin/sh
# compile and run the link test simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_link_test -o sim_link_test
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_link_test > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
